// ==== bootRom.hex ====
// boot ROM words 0 to 15, one 16-bit hex word per line
A5F0
0001
8000
7F3C
C0DE
1100
00FF
4E71
2A2A
9B07
0F0F
3C5A
1000
E41D
6B82
FFFF

// ==== peripheralSoc.f ====
logic/socBusPkg.sv
logic/periphBus.sv
logic/memoryController.sv
logic/bootRom.sv
logic/workRam.sv
logic/uartTx.sv
logic/gpioPort.sv
logic/pwmLed.sv
logic/peripheralSoc.sv
tb/peripheralSocTb.sv

// ==== Makefile ====
# Verilator build and run of the peripheral subsystem testbench

SRCS := $(wildcard logic/*.sv) tb/peripheralSocTb.sv

obj_dir/VperipheralSocTb: peripheralSoc.f $(SRCS)
	verilator --binary --assert -Wno-fatal --top-module peripheralSocTb -f peripheralSoc.f -o VperipheralSocTb

run: obj_dir/VperipheralSocTb
	./obj_dir/VperipheralSocTb

clean:
	rm -rf obj_dir

.PHONY: run clean

// ==== tb/peripheralSocTb.sv ====
// Testbench for the peripheral subsystem
// random Wishbone traffic checked against ROM and RAM models,
// plus GPIO readback, LED PWM duty counts and UART frame sampling

`timescale 1ns/1ns

module peripheralSocTb import socBusPkg::*; ();

	localparam int timeoutCycles = 40000; // all tests together take a few thousand cycles

	logic CLK;
	logic RSTb;
	logic wbCyc;
	logic wbStb;
	logic wbWe;
	logic [addrBits-1:0] wbAdr;
	logic [dataBits-1:0] wbDatW;
	logic [dataBits-1:0] wbDatR;
	logic wbAck;
	logic [7:0] gpioIn;
	logic [7:0] gpioOut;
	logic uartTxd;
	logic [2:0] ledOut;

	logic [15:0] lfsr = 16'd22;
	int cycleCount = 0;
	logic ackPrev = 1'b0;
	logic [dataBits-1:0] romModel [romWords];
	logic [dataBits-1:0] ramModel [ramWords];
	logic ramWritten [ramWords]; // only written words are read back

	peripheralSoc u_peripheralSoc (
		.CLK(CLK), .RSTb(RSTb),
		.wbCyc(wbCyc), .wbStb(wbStb), .wbWe(wbWe),
		.wbAdr(wbAdr), .wbDatW(wbDatW), .wbDatR(wbDatR), .wbAck(wbAck),
		.gpioIn(gpioIn), .uartTxd(uartTxd), .gpioOut(gpioOut), .ledOut(ledOut)
	);

	initial begin
		CLK = 1'b0;
		forever #2 CLK = ~CLK;
	end

	task automatic stopRun();
		$display("Some tests failed");
		$fatal(1, "simulation stopped at the first failure");
	endtask

	always @(posedge CLK) begin
		cycleCount <= cycleCount + 1;
		if (cycleCount >= timeoutCycles) begin
			$display("timeout, the run did not finish within %0d cycles", timeoutCycles);
			stopRun();
		end
	end

	// ack must never last two cycles
	always @(negedge CLK) begin
		if (RSTb) begin
			assert (!(wbAck && ackPrev)) else begin
				$display("wbAck was high on two consecutive cycles");
				stopRun();
			end
		end
		ackPrev = wbAck;
	end

	// galois lfsr stepped once per bit taken
	function automatic logic [15:0] randomBits(input int n);
		logic [15:0] value;
		value = '0;
		for (int i = 0; i < n; i++) begin
			lfsr = lfsr[0] ? ((lfsr >> 1) ^ 16'hB400) : (lfsr >> 1);
			value = {value[14:0], lfsr[0]};
		end
		return value;
	endfunction

	task automatic checkValue(input string name, input logic [15:0] got,
			input logic [15:0] expected);
		assert (got === expected) else begin
			$display("error %s got 0x%04h expected 0x%04h", name, got, expected);
			stopRun();
		end
	endtask

	// one classic cycle that ends at the falling edge where ack is seen
	task automatic transfer(input logic we, input logic [15:0] adr,
			input logic [15:0] datW, output logic [15:0] datR);
		int waited;
		@(negedge CLK);
		wbCyc = 1'b1;
		wbStb = 1'b1;
		wbWe = we;
		wbAdr = adr;
		wbDatW = datW;
		@(negedge CLK);
		waited = 1;
		while (!wbAck && waited < 4) begin // watchdog
			@(negedge CLK);
			waited++;
		end
		assert (wbAck) else begin
			$display("no acknowledge within 4 cycles for address 0x%04h", adr);
			stopRun();
		end
		assert (waited == 1) else begin
			$display("acknowledge came %0d cycles after the request", waited);
			stopRun();
		end
		datR = wbDatR;
		wbCyc = 1'b0;
		wbStb = 1'b0;
		wbWe = 1'b0;
	endtask

	task automatic busWrite(input logic [15:0] adr, input logic [15:0] data);
		logic [15:0] ignored;
		transfer(1'b1, adr, data, ignored);
	endtask

	task automatic busRead(input logic [15:0] adr, output logic [15:0] data);
		transfer(1'b0, adr, 16'h0000, data);
	endtask

	task automatic readExpect(input logic [15:0] adr, input logic [15:0] expected);
		logic [15:0] got;
		busRead(adr, got);
		checkValue("wbDatR", got, expected);
	endtask

	task automatic waitCycle(input int target);
		while (cycleCount < target)
			@(negedge CLK);
		assert (cycleCount == target) else begin
			$display("UART sample point at cycle %0d was missed", target);
			stopRun();
		end
	endtask

	initial begin
		logic [15:0] adr;
		logic [15:0] data;
		logic [15:0] upper;
		logic [15:0] low;
		logic [15:0] status;
		logic [7:0] txByte;
		logic [7:0] duty [3];
		logic expectedBit;
		int highCount [3];
		int polls;
		int c0;
		RSTb = 1'b0;
		wbCyc = 1'b0;
		wbStb = 1'b0;
		wbWe = 1'b0;
		wbAdr = '0;
		wbDatW = '0;
		gpioIn = '0;
		for (int i = 0; i < ramWords; i++)
			ramWritten[i] = 1'b0;
		for (int i = 0; i < romWords; i++)
			romModel[i] = '0;
		$readmemh("bootRom.hex", romModel);
		repeat (16) @(negedge CLK);
		checkValue("wbAck", {15'd0, wbAck}, 16'h0000);
		checkValue("wbDatR", wbDatR, 16'h0000);
		checkValue("uartTxd", {15'd0, uartTxd}, 16'h0001);
		checkValue("gpioOut", {8'h00, gpioOut}, 16'h0000);
		checkValue("ledOut", {13'd0, ledOut}, 16'h0000);
		RSTb = 1'b1;

		for (int a = 0; a < 32; a++) // words past the file read zero
			readExpect(16'(a), romModel[a]);
		busWrite(16'h0005, ~romModel[5]);
		readExpect(16'h0005, romModel[5]);

		// request held through ack gets a second ack two cycles later
		@(negedge CLK);
		wbCyc = 1'b1;
		wbStb = 1'b1;
		wbAdr = 16'h0003;
		@(negedge CLK);
		checkValue("wbAck", {15'd0, wbAck}, 16'h0001);
		checkValue("wbDatR", wbDatR, romModel[3]);
		@(negedge CLK);
		checkValue("wbAck", {15'd0, wbAck}, 16'h0000);
		@(negedge CLK);
		checkValue("wbAck", {15'd0, wbAck}, 16'h0001);
		checkValue("wbDatR", wbDatR, romModel[3]);
		wbCyc = 1'b0;
		wbStb = 1'b0;

		for (int n = 0; n < 200; n++) begin
			upper = randomBits(3); // aliases of a few low words
			low = randomBits(5);
			adr = 16'h8000 | (upper << 12) | low;
			if (randomBits(1) == 16'h0001 && ramWritten[adr[11:0]])
				readExpect(adr, ramModel[adr[11:0]]);
			else begin
				data = randomBits(16);
				busWrite(adr, data);
				ramModel[adr[11:0]] = data;
				ramWritten[adr[11:0]] = 1'b1;
			end
		end
		busWrite(16'h2000, 16'hFFFF);
		readExpect(16'h2000, 16'h0000);
		readExpect(16'h1300, 16'h0000);
		readExpect(16'h7FFE, 16'h0000);

		for (int n = 0; n < 8; n++) begin
			data = randomBits(8);
			busWrite(16'h1100, data);
			checkValue("gpioOut", {8'h00, gpioOut}, data);
			readExpect(16'h1100, data);
			data = randomBits(8);
			gpioIn = data[7:0];
			repeat (3) @(negedge CLK); // through the synchronizer
			readExpect(16'h1101, {8'h00, gpioIn});
		end

		for (int r = 0; r < 4; r++) begin
			for (int ch = 0; ch < 3; ch++) begin
				data = randomBits(8);
				duty[ch] = data[7:0];
				busWrite(16'h1200 + 16'(ch), data);
				highCount[ch] = 0;
			end
			repeat (2) @(negedge CLK);
			repeat (256) begin // one full counter period
				@(negedge CLK);
				for (int ch = 0; ch < 3; ch++)
					highCount[ch] += int'(ledOut[ch]);
			end
			for (int ch = 0; ch < 3; ch++)
				checkValue($sformatf("ledOut[%0d] high cycles", ch), 16'(highCount[ch]),
					{8'h00, duty[ch]});
		end

		for (int n = 0; n < 8; n++) begin
			data = randomBits(8);
			txByte = data[7:0];
			busWrite(16'h1000, data);
			c0 = cycleCount; // start bit begins on this edge
			status = '0;
			polls = 0;
			while (!status[0]) begin
				assert (polls < 2) else begin
					$display("UART status never reported busy after a write");
					stopRun();
				end
				busRead(16'h1001, status);
				polls++;
			end
			for (int k = 0; k < 10; k++) begin
				waitCycle(c0 + baudDivider * k + baudDivider / 2); // middle of bit k
				if (k == 0)
					expectedBit = 1'b0;
				else if (k == 9)
					expectedBit = 1'b1;
				else
					expectedBit = txByte[k-1];
				checkValue("uartTxd", {15'd0, uartTxd}, {15'd0, expectedBit});
				if (k == 0)
					busWrite(16'h1000, {8'h00, ~txByte}); // dropped while busy
			end
			waitCycle(c0 + baudDivider * 10);
			readExpect(16'h1001, 16'h0000);
		end

		$display("All tests passed");
		$finish;
	end

endmodule

// ==== logic/peripheralSoc.sv ====
// Peripheral subsystem top level
// Wishbone classic slave port in front of the memory controller,
// boot ROM, work RAM, UART transmitter, GPIO and LED PWM

`timescale 1ns/1ns

module peripheralSoc import socBusPkg::*; (
	input logic CLK,
	input logic RSTb,
	input logic wbCyc,
	input logic wbStb,
	input logic wbWe,
	input logic [addrBits-1:0] wbAdr,
	input logic [dataBits-1:0] wbDatW,
	output logic [dataBits-1:0] wbDatR,
	output logic wbAck,
	input logic [7:0] gpioIn,
	output logic uartTxd,
	output logic [7:0] gpioOut,
	output logic [2:0] ledOut
);

	logic [memAddrBits-1:0] memAddr;
	logic [dataBits-1:0] ramWrData;
	logic ramWe;
	logic [dataBits-1:0] romData;
	logic [dataBits-1:0] ramData;

	periphBus uartBus ();
	periphBus gpioBus ();
	periphBus pwmBus ();

	memoryController u_memoryController (
		.CLK(CLK), .RSTb(RSTb),
		.wbCyc(wbCyc), .wbStb(wbStb), .wbWe(wbWe),
		.wbAdr(wbAdr), .wbDatW(wbDatW), .wbDatR(wbDatR), .wbAck(wbAck),
		.memAddr(memAddr), .ramWrData(ramWrData), .ramWe(ramWe),
		.romData(romData), .ramData(ramData),
		.uartBus(uartBus), .gpioBus(gpioBus), .pwmBus(pwmBus)
	);

	bootRom u_bootRom (.CLK(CLK), .addr(memAddr), .data(romData));

	workRam u_workRam (
		.CLK(CLK), .addr(memAddr), .wrData(ramWrData), .we(ramWe), .rdData(ramData)
	);

	uartTx u_uartTx (.CLK(CLK), .RSTb(RSTb), .regs(uartBus), .txd(uartTxd));

	gpioPort u_gpioPort (
		.CLK(CLK), .RSTb(RSTb), .pinsIn(gpioIn), .regs(gpioBus), .pinsOut(gpioOut)
	);

	pwmLed u_pwmLed (.CLK(CLK), .RSTb(RSTb), .regs(pwmBus), .led(ledOut));

endmodule

// ==== logic/pwmLed.sv ====
// Three-channel LED PWM
// registers 0 to 2 hold the duty of each LED. One free-running
// counter is shared, a channel is on while counter < duty.

`timescale 1ns/1ns

module pwmLed import socBusPkg::*; (
	input logic CLK,
	input logic RSTb,
	periphBus.dev regs,
	output logic [2:0] led
);

	logic [pwmBits-1:0] counter; // wraps every 256 clocks
	logic [pwmBits-1:0] duty [3];

	always_ff @(posedge CLK) begin
		if (!RSTb) begin
			counter <= '0;
			led <= '0;
			for (int i = 0; i < 3; i++)
				duty[i] <= '0;
		end else begin
			counter <= counter + 1'b1;
			for (int i = 0; i < 3; i++) begin
				led[i] <= (counter < duty[i]); // registered compare
				if (regs.wrEn && regs.regAddr == 8'(i))
					duty[i] <= regs.wrData[pwmBits-1:0];
			end
		end
	end

	always_comb begin
		case (regs.regAddr)
			8'h00: regs.rdData = {8'h00, duty[0]};
			8'h01: regs.rdData = {8'h00, duty[1]};
			8'h02: regs.rdData = {8'h00, duty[2]};
			default: regs.rdData = '0;
		endcase
	end

	for (genvar ch = 0; ch < 3; ch++) begin : gDutyCheck
		zeroDutyOff: assert property (@(posedge CLK) disable iff (!RSTb)
			(duty[ch] == '0) |=> !led[ch]);
	end

endmodule

// ==== logic/gpioPort.sv ====
// GPIO port
// register 0 is the 8-bit output latch, register 1 reads the
// input pins through a two-flop synchronizer

`timescale 1ns/1ns

module gpioPort import socBusPkg::*; (
	input logic CLK,
	input logic RSTb,
	input logic [7:0] pinsIn,
	periphBus.dev regs,
	output logic [7:0] pinsOut
);

	logic [7:0] syncA;
	logic [7:0] syncB; // two clocks behind the pins

	always_ff @(posedge CLK) begin
		if (!RSTb)
			pinsOut <= '0;
		else if (regs.wrEn && regs.regAddr == 8'h00)
			pinsOut <= regs.wrData[7:0];
	end

	always_ff @(posedge CLK) begin
		syncA <= pinsIn;
		syncB <= syncA;
	end

	always_comb begin
		case (regs.regAddr)
			8'h00: regs.rdData = {8'h00, pinsOut};
			8'h01: regs.rdData = {8'h00, syncB};
			default: regs.rdData = '0;
		endcase
	end

endmodule

// ==== logic/uartTx.sv ====
// UART transmitter, 8N1
// register 0 takes the byte to send, register 1 reads busy in bit 0.
// Each bit lasts baudDivider clocks, data goes out LSB first.

`timescale 1ns/1ns

module uartTx import socBusPkg::*; (
	input logic CLK,
	input logic RSTb,
	periphBus.dev regs,
	output logic txd
);

	uartStateT state;
	logic [baudCntBits-1:0] baudCnt;
	logic [2:0] bitCnt;
	logic [7:0] shiftReg;
	logic [7:0] lastByte; // readback of the data register
	logic busy;
	logic bitEnd;

	assign busy = (state != idleState);
	assign bitEnd = (baudCnt == baudCntBits'(baudDivider - 1));

	always_ff @(posedge CLK) begin
		if (!RSTb) begin
			state <= idleState;
			baudCnt <= '0;
			bitCnt <= '0;
			txd <= 1'b1;
		end else begin
			if (state == idleState) begin
				txd <= 1'b1;
				if (regs.wrEn && regs.regAddr == 8'h00) begin // writes while busy are dropped
					state <= startState;
					baudCnt <= '0;
					txd <= 1'b0; // start bit
				end
			end else if (bitEnd) begin
				baudCnt <= '0;
				case (state)
					startState: begin
						state <= dataState;
						bitCnt <= '0;
						txd <= shiftReg[0];
					end
					dataState: begin
						if (bitCnt == 3'd7) begin
							state <= stopState;
							txd <= 1'b1;
						end else begin
							bitCnt <= bitCnt + 3'd1;
							txd <= shiftReg[1];
						end
					end
					default: state <= idleState; // end of stop bit
				endcase
			end else
				baudCnt <= baudCnt + 1'b1;
		end
	end

	// load the byte and shift once per data bit
	always_ff @(posedge CLK) begin
		if (state == idleState && regs.wrEn && regs.regAddr == 8'h00) begin
			shiftReg <= regs.wrData[7:0];
			lastByte <= regs.wrData[7:0];
		end else if (state == dataState && bitEnd)
			shiftReg <= shiftReg >> 1;
	end

	always_comb begin
		case (regs.regAddr)
			8'h00: regs.rdData = {8'h00, lastByte};
			8'h01: regs.rdData = {15'd0, busy};
			default: regs.rdData = '0;
		endcase
	end

	idleLineHigh: assert property (@(posedge CLK) disable iff (!RSTb)
		(state == idleState) |-> txd);

endmodule

// ==== logic/workRam.sv ====
// Work RAM
// 4k x 16 single-port synchronous RAM, write-first,
// so a write also returns the new word on the next clock

`timescale 1ns/1ns

module workRam import socBusPkg::*; (
	input logic CLK,
	input logic [memAddrBits-1:0] addr,
	input logic [dataBits-1:0] wrData,
	input logic we,
	output logic [dataBits-1:0] rdData
);

	logic [dataBits-1:0] mem [ramWords];

	always_ff @(posedge CLK) begin
		if (we) begin
			mem[addr] <= wrData;
			rdData <= wrData; // write-first
		end else
			rdData <= mem[addr];
	end

endmodule

// ==== logic/bootRom.sv ====
// Boot ROM
// 4k x 16 synchronous read, contents from bootRom.hex,
// words past the end of the file read as zero

`timescale 1ns/1ns

module bootRom import socBusPkg::*; (
	input logic CLK,
	input logic [memAddrBits-1:0] addr,
	output logic [dataBits-1:0] data
);

	logic [dataBits-1:0] mem [romWords];

	initial begin
		for (int i = 0; i < romWords; i++)
			mem[i] = '0;
		$readmemh("bootRom.hex", mem); // short file fills the low words only
	end

	always_ff @(posedge CLK)
		data <= mem[addr];

endmodule

// ==== logic/memoryController.sv ====
// Memory controller
// Wishbone classic slave that decodes each request into ROM, RAM or
// one of three peripheral register buses. Every access is acked one
// clock after the request, with read data valid in the ack cycle.

`timescale 1ns/1ns

module memoryController import socBusPkg::*; (
	input logic CLK,
	input logic RSTb,
	input logic wbCyc,
	input logic wbStb,
	input logic wbWe,
	input logic [addrBits-1:0] wbAdr,
	input logic [dataBits-1:0] wbDatW,
	output logic [dataBits-1:0] wbDatR,
	output logic wbAck,
	output logic [memAddrBits-1:0] memAddr,
	output logic [dataBits-1:0] ramWrData,
	output logic ramWe,
	input logic [dataBits-1:0] romData,
	input logic [dataBits-1:0] ramData,
	periphBus.ctrl uartBus,
	periphBus.ctrl gpioBus,
	periphBus.ctrl pwmBus
);

	regionT region;
	regionT regionQ; // region of the request being acked
	logic reqSeen;
	logic wrSeen;
	logic [dataBits-1:0] periphDataQ;

	// a held request is not seen again in its own ack cycle
	assign reqSeen = wbCyc && wbStb && !wbAck;
	assign wrSeen = reqSeen && wbWe;

	always_comb begin
		casez (wbAdr)
			16'h0???: region = romRegion;
			16'h10??: region = uartRegion;
			16'h11??: region = gpioRegion;
			16'h12??: region = pwmRegion;
			16'b1???_????_????_????: region = ramRegion; // 4k words, aliased
			default: region = noRegion;
		endcase
	end

	assign memAddr = wbAdr[memAddrBits-1:0];
	assign ramWrData = wbDatW;
	assign ramWe = wrSeen && (region == ramRegion);

	assign uartBus.regAddr = wbAdr[regAddrBits-1:0];
	assign uartBus.wrData = wbDatW;
	assign uartBus.wrEn = wrSeen && (region == uartRegion);
	assign gpioBus.regAddr = wbAdr[regAddrBits-1:0];
	assign gpioBus.wrData = wbDatW;
	assign gpioBus.wrEn = wrSeen && (region == gpioRegion);
	assign pwmBus.regAddr = wbAdr[regAddrBits-1:0];
	assign pwmBus.wrData = wbDatW;
	assign pwmBus.wrEn = wrSeen && (region == pwmRegion);

	always_ff @(posedge CLK) begin
		if (!RSTb) begin
			wbAck <= 1'b0;
			regionQ <= noRegion; // keeps wbDatR at zero
		end else begin
			wbAck <= reqSeen;
			if (reqSeen)
				regionQ <= region;
		end
	end

	// peripheral read data captured on the same edge as rom and ram
	always_ff @(posedge CLK) begin
		if (reqSeen) begin
			case (region)
				uartRegion: periphDataQ <= uartBus.rdData;
				gpioRegion: periphDataQ <= gpioBus.rdData;
				pwmRegion: periphDataQ <= pwmBus.rdData;
				default: periphDataQ <= '0;
			endcase
		end
	end

	always_comb begin
		case (regionQ)
			romRegion: wbDatR = romData;
			ramRegion: wbDatR = ramData;
			uartRegion, gpioRegion, pwmRegion: wbDatR = periphDataQ;
			default: wbDatR = '0; // unmapped reads return zero
		endcase
	end

	ackSingleCycle: assert property (@(posedge CLK) disable iff (!RSTb)
		wbAck |=> !wbAck);

	oneWriteStrobe: assert property (@(posedge CLK) disable iff (!RSTb)
		$onehot0({ramWe, uartBus.wrEn, gpioBus.wrEn, pwmBus.wrEn}));

endmodule

// ==== logic/periphBus.sv ====
// Register bus from the memory controller to one peripheral
// single-cycle write strobe, combinational read data back

`timescale 1ns/1ns

interface periphBus import socBusPkg::*; ();

	logic [regAddrBits-1:0] regAddr; // low byte of the bus address
	logic [dataBits-1:0] wrData;
	logic wrEn; // one clock wide
	logic [dataBits-1:0] rdData; // driven from peripheral registers

	modport ctrl (
		output regAddr, wrData, wrEn,
		input rdData
	);

	modport dev (
		input regAddr, wrData, wrEn,
		output rdData
	);

endinterface

// ==== logic/socBusPkg.sv ====
// Shared definitions for the peripheral subsystem
// widths, memory sizes, peripheral timing and the enums
// used by the controller decoder and the UART transmitter

package socBusPkg;

	localparam int dataBits = 16; // bus and memory word width
	localparam int addrBits = 16; // wishbone address width
	localparam int regAddrBits = 8; // low address byte into a peripheral
	localparam int memAddrBits = 12; // rom and ram index, address bits 11:0

	localparam int romWords = 4096;
	localparam int ramWords = 4096;

	localparam int baudDivider = 8; // clocks per uart bit
	localparam int baudCntBits = $clog2(baudDivider);

	localparam int pwmBits = 8; // counter and duty width

	typedef enum logic [2:0] {
		romRegion,
		uartRegion,
		gpioRegion,
		pwmRegion,
		ramRegion,
		noRegion
	} regionT;

	typedef enum logic [1:0] {
		idleState,
		startState,
		dataState,
		stopState
	} uartStateT;

endpackage
